/* logic/vdp_pkg.sv */
`default_nettype none

package vdp_pkg;

  // ==============================
  // Widths and sizes
  // ==============================
  localparam int WORD_W     = 64;
  localparam int ADDR_W     = 32;
  localparam int CSR_ADDR_W = 12;
  localparam int NUM_LANES  = 8;
  localparam int IDX_W      = 3;
  localparam int LEN_W      = IDX_W + 1;  // Holds 0..NUM_LANES.
  localparam int ELEM_BYTES = 8;

  // ==============================
  // Register offsets
  // ==============================
  localparam logic [CSR_ADDR_W-1:0] CSR_A_PTR   = 12'h000;
  localparam logic [CSR_ADDR_W-1:0] CSR_B_PTR   = 12'h040;
  localparam logic [CSR_ADDR_W-1:0] CSR_LEN     = 12'h080;
  localparam logic [CSR_ADDR_W-1:0] CSR_START   = 12'h0c0;
  localparam logic [CSR_ADDR_W-1:0] CSR_STATUS  = 12'h100;  // Read only.
  localparam logic [CSR_ADDR_W-1:0] CSR_RES_PTR = 12'h140;

  // ==============================
  // Types
  // ==============================
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  typedef struct packed {
    logic                  wr;
    logic [CSR_ADDR_W-1:0] addr;
    word_t                 data;
  } io_cmd_t;

  typedef struct packed {
    logic                  wr;    // Echo of the command.
    logic [CSR_ADDR_W-1:0] addr;  // Echo of the command.
    word_t                 data;
  } io_resp_t;

  typedef struct packed {
    addr_t            a_ptr;
    addr_t            b_ptr;
    addr_t            res_ptr;
    logic [LEN_W-1:0] len;  // Already clamped.
  } vdp_cfg_t;

  typedef struct packed {
    logic  wr;
    addr_t addr;
    word_t data;
  } mem_req_t;

  typedef struct packed {
    logic             v;
    logic [IDX_W-1:0] idx;
    logic             sel_b;  // Element belongs to vector B.
    word_t            data;
  } lane_wr_t;

endpackage

`default_nettype wire

/* logic/vdp_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_csr (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              io_cmd_v_i,
  input  vdp_pkg::io_cmd_t  io_cmd_i,
  output logic              io_resp_v_o,
  output vdp_pkg::io_resp_t io_resp_o,
  input  logic              done_i,
  output vdp_pkg::vdp_cfg_t cfg_o,
  output logic              go_o
);
  import vdp_pkg::*;

  vdp_cfg_t cfg_q;
  word_t    start_q;
  logic     busy_q;
  logic     wr_en;
  logic     start_hit;
  word_t    rdata;

  assign wr_en     = io_cmd_v_i && io_cmd_i.wr;
  assign start_hit = wr_en && (io_cmd_i.addr == CSR_START) && (io_cmd_i.data != '0);
  assign cfg_o     = cfg_q;

  // ==============================
  // Register writes
  // ==============================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q   <= '0;
      start_q <= '0;
    end else begin
      if (wr_en) begin
        case (io_cmd_i.addr)
          CSR_A_PTR:   cfg_q.a_ptr   <= io_cmd_i.data[ADDR_W-1:0];
          CSR_B_PTR:   cfg_q.b_ptr   <= io_cmd_i.data[ADDR_W-1:0];
          CSR_RES_PTR: cfg_q.res_ptr <= io_cmd_i.data[ADDR_W-1:0];
          CSR_START:   start_q       <= io_cmd_i.data;
          CSR_LEN: begin
            if (io_cmd_i.data > word_t'(NUM_LANES)) begin
              cfg_q.len <= LEN_W'(NUM_LANES);  // Clamp to lane count.
            end else begin
              cfg_q.len <= io_cmd_i.data[LEN_W-1:0];
            end
          end
          default: ;
        endcase
      end
      if (done_i) begin
        start_q <= '0;  // Job finished.
      end
    end
  end

  // Job launch and busy tracking.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      go_o   <= 1'b0;
    end else begin
      go_o <= start_hit && !busy_q;
      if (start_hit && !busy_q) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // ==============================
  // Read path and response
  // ==============================
  always_comb begin
    rdata = '0;
    case (io_cmd_i.addr)
      CSR_A_PTR:   rdata = word_t'(cfg_q.a_ptr);
      CSR_B_PTR:   rdata = word_t'(cfg_q.b_ptr);
      CSR_LEN:     rdata = word_t'(cfg_q.len);
      CSR_START:   rdata = start_q;
      CSR_STATUS:  rdata = word_t'(!busy_q);  // 1 when idle.
      CSR_RES_PTR: rdata = word_t'(cfg_q.res_ptr);
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      io_resp_v_o <= 1'b0;
    end else begin
      io_resp_v_o <= io_cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    io_resp_o.wr   <= io_cmd_i.wr;
    io_resp_o.addr <= io_cmd_i.addr;
    io_resp_o.data <= io_cmd_i.wr ? '0 : rdata;
  end

  // Done only ends a job that is running.
  a_done_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    done_i |-> busy_q);

endmodule

`default_nettype wire

/* logic/vdp_fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_fetch_ctrl (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              go_i,
  input  vdp_pkg::vdp_cfg_t cfg_i,
  input  vdp_pkg::word_t    sum_i,
  output logic              mem_req_v_o,
  output vdp_pkg::mem_req_t mem_req_o,
  input  logic              mem_resp_v_i,
  input  vdp_pkg::word_t    mem_rdata_i,
  output logic              lane_clr_o,
  output vdp_pkg::lane_wr_t lane_wr_o,
  output logic              done_o
);
  import vdp_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_ISSUE,
    S_WAIT,
    S_SETTLE,
    S_STORE,
    S_STORE_WAIT
  } state_e;

  state_e           state_q;
  logic [LEN_W-1:0] cnt_q;
  logic             sel_b_q;
  logic             settle_q;
  logic             last_elem;
  logic             is_store;
  addr_t            elem_base;
  addr_t            elem_addr;

  assign last_elem = LEN_W'(cnt_q + 1'b1) == cfg_i.len;
  assign is_store  = (state_q == S_STORE);
  assign elem_base = sel_b_q ? cfg_i.b_ptr : cfg_i.a_ptr;
  assign elem_addr = elem_base + addr_t'(cnt_q) * addr_t'(ELEM_BYTES);

  // ==============================
  // Memory request and lane writes
  // ==============================
  assign mem_req_v_o    = (state_q == S_ISSUE) || is_store;
  assign mem_req_o.wr   = is_store;
  assign mem_req_o.addr = is_store ? cfg_i.res_ptr : elem_addr;
  assign mem_req_o.data = is_store ? sum_i : '0;

  assign lane_clr_o      = (state_q == S_IDLE) && go_i;  // Wipe stale lanes.
  assign lane_wr_o.v     = (state_q == S_WAIT) && mem_resp_v_i;
  assign lane_wr_o.idx   = cnt_q[IDX_W-1:0];
  assign lane_wr_o.sel_b = sel_b_q;
  assign lane_wr_o.data  = mem_rdata_i;

  // ==============================
  // FSM
  // ==============================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= S_IDLE;
      cnt_q    <= '0;
      sel_b_q  <= 1'b0;
      settle_q <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (go_i) begin
            cnt_q    <= '0;
            sel_b_q  <= 1'b0;
            settle_q <= 1'b0;
            // Zero length skips straight to the store of a cleared sum.
            state_q  <= (cfg_i.len == '0) ? S_SETTLE : S_ISSUE;
          end
        end
        S_ISSUE: begin
          state_q <= S_WAIT;
        end
        S_WAIT: begin
          if (mem_resp_v_i) begin
            if (!last_elem) begin
              cnt_q   <= cnt_q + 1'b1;
              state_q <= S_ISSUE;
            end else if (!sel_b_q) begin
              cnt_q   <= '0;  // Move on to vector B.
              sel_b_q <= 1'b1;
              state_q <= S_ISSUE;
            end else begin
              state_q <= S_SETTLE;
            end
          end
        end
        S_SETTLE: begin
          settle_q <= 1'b1;  // Lane product, then tree sum.
          if (settle_q) begin
            state_q <= S_STORE;
          end
        end
        S_STORE: begin
          state_q <= S_STORE_WAIT;
        end
        S_STORE_WAIT: begin
          if (mem_resp_v_i) begin
            done_o  <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Only one request may be in flight at the memory.
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_o |=> !mem_req_v_o until_with mem_resp_v_i);

endmodule

`default_nettype wire

/* logic/vdp_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_lane #(
  parameter int LANE_IDX = 0
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              clr_i,
  input  vdp_pkg::lane_wr_t wr_i,
  output vdp_pkg::word_t    prod_o
);
  import vdp_pkg::*;

  word_t a_q;
  word_t b_q;
  logic  hit;

  assign hit = wr_i.v && (wr_i.idx == IDX_W'(LANE_IDX));

  always_ff @(posedge clk_i) begin
    if (reset_i || clr_i) begin
      a_q <= '0;
      b_q <= '0;
    end else if (hit) begin
      if (wr_i.sel_b) begin
        b_q <= wr_i.data;
      end else begin
        a_q <= wr_i.data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    prod_o <= a_q * b_q;  // Low 64 bits only.
  end

  // Controller must hand over a defined index with every write.
  a_idx_known: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_i.v |-> !$isunknown(wr_i.idx));

endmodule

`default_nettype wire

/* logic/vdp_adder_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_adder_tree (
  input  logic           clk_i,
  input  logic           reset_i,
  input  vdp_pkg::word_t prod_i [vdp_pkg::NUM_LANES],
  output vdp_pkg::word_t sum_o
);
  import vdp_pkg::*;

  word_t lvl1 [NUM_LANES/2];
  word_t lvl2 [NUM_LANES/4];
  word_t total;

  // ==============================
  // Pairwise reduction
  // ==============================
  for (genvar i = 0; i < NUM_LANES / 2; i++) begin : g_lvl1
    assign lvl1[i] = prod_i[2*i] + prod_i[2*i+1];
  end

  for (genvar i = 0; i < NUM_LANES / 4; i++) begin : g_lvl2
    assign lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
  end

  assign total = lvl2[0] + lvl2[1];  // Wraps modulo 2^64.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sum_o <= '0;
    end else begin
      sum_o <= total;
    end
  end

endmodule

`default_nettype wire

/* logic/vdp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_top (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              io_cmd_v_i,
  input  vdp_pkg::io_cmd_t  io_cmd_i,
  output logic              io_resp_v_o,
  output vdp_pkg::io_resp_t io_resp_o,
  output logic              mem_req_v_o,
  output vdp_pkg::mem_req_t mem_req_o,
  input  logic              mem_resp_v_i,
  input  vdp_pkg::word_t    mem_rdata_i
);
  import vdp_pkg::*;

  vdp_cfg_t cfg;
  logic     go;
  logic     done;
  logic     lane_clr;
  lane_wr_t lane_wr;
  word_t    prod [NUM_LANES];
  word_t    sum;

  vdp_csr u_csr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .io_cmd_v_i  (io_cmd_v_i),
    .io_cmd_i    (io_cmd_i),
    .io_resp_v_o (io_resp_v_o),
    .io_resp_o   (io_resp_o),
    .done_i      (done),
    .cfg_o       (cfg),
    .go_o        (go)
  );

  vdp_fetch_ctrl u_fetch_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .go_i         (go),
    .cfg_i        (cfg),
    .sum_i        (sum),
    .mem_req_v_o  (mem_req_v_o),
    .mem_req_o    (mem_req_o),
    .mem_resp_v_i (mem_resp_v_i),
    .mem_rdata_i  (mem_rdata_i),
    .lane_clr_o   (lane_clr),
    .lane_wr_o    (lane_wr),
    .done_o       (done)
  );

  // One lane per element; all see the same write bus.
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    vdp_lane #(
      .LANE_IDX (i)
    ) u_lane (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .clr_i   (lane_clr),
      .wr_i    (lane_wr),
      .prod_o  (prod[i])
    );
  end

  vdp_adder_tree u_adder_tree (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .prod_i  (prod),
    .sum_o   (sum)
  );

endmodule

`default_nettype wire

/* test/vdp_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_mem_model (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_v_i,
  input  vdp_pkg::mem_req_t req_i,
  output logic              resp_v_o,
  output vdp_pkg::word_t    rdata_o
);
  import vdp_pkg::*;

  word_t       mem [addr_t];
  mem_req_t    req_q;
  logic        pending_q;
  int unsigned wait_q;

  task automatic preload(input addr_t addr, input word_t data);
    mem[addr] = data;
  endtask

  initial begin
    resp_v_o = 1'b0;
    rdata_o  = '0;
  end

  // Runs on falling edges, so each answer is stable at the next rising edge.
  always @(negedge clk_i) begin
    if (reset_i) begin
      resp_v_o  <= 1'b0;
      pending_q <= 1'b0;
      wait_q    <= 0;
    end else begin
      resp_v_o <= 1'b0;
      if (pending_q && wait_q == 1) begin
        resp_v_o  <= 1'b1;
        pending_q <= 1'b0;
        if (req_q.wr) begin
          mem[req_q.addr] = req_q.data;
        end else begin
          rdata_o <= mem.exists(req_q.addr) ? mem[req_q.addr] : '0;  // Unwritten reads zero.
        end
      end else if (pending_q) begin
        wait_q <= wait_q - 1;
      end
      if (req_v_i) begin
        req_q     <= req_i;
        pending_q <= 1'b1;
        wait_q    <= 1 + $urandom_range(3);  // 1 to 4 cycles.
      end
    end
  end

endmodule

`default_nettype wire

/* test/vdp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_tb;
  import vdp_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TESTS   = 26;
  localparam int JOB_REQS    = 2 * NUM_LANES + 1;
  localparam int DONE_LIMIT  = JOB_REQS * 5 + 20;
  localparam int WATCHDOG_NS = NUM_TESTS * (JOB_REQS * 5 + 40) * CLK_PERIOD;

  logic     clk;
  logic     reset;
  logic     io_cmd_v;
  io_cmd_t  io_cmd;
  logic     io_resp_v;
  io_resp_t io_resp;
  logic     mem_req_v;
  mem_req_t mem_req;
  logic     mem_resp_v;
  word_t    mem_rdata;

  int       errors;
  int       checks;
  io_resp_t exp_q [$];
  mem_req_t req_log [$];
  word_t    va [NUM_LANES];
  word_t    vb [NUM_LANES];

  vdp_top u_vdp_top (
    .clk_i        (clk),
    .reset_i      (reset),
    .io_cmd_v_i   (io_cmd_v),
    .io_cmd_i     (io_cmd),
    .io_resp_v_o  (io_resp_v),
    .io_resp_o    (io_resp),
    .mem_req_v_o  (mem_req_v),
    .mem_req_o    (mem_req),
    .mem_resp_v_i (mem_resp_v),
    .mem_rdata_i  (mem_rdata)
  );

  vdp_mem_model u_mem (
    .clk_i    (clk),
    .reset_i  (reset),
    .req_v_i  (mem_req_v),
    .req_i    (mem_req),
    .resp_v_o (mem_resp_v),
    .rdata_o  (mem_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Sum of low 64-bit lane products, length clamped to the lane count.
  function automatic word_t dot_ref(input word_t a [NUM_LANES], input word_t b [NUM_LANES],
                                    input int len);
    word_t sum;
    int    n;
    sum = '0;
    n   = (len > NUM_LANES) ? NUM_LANES : len;
    for (int i = 0; i < n; i++) begin
      sum += a[i] * b[i];
    end
    return sum;
  endfunction

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input io_resp_t got, input io_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Compare process for host responses; also logs memory requests.
  always @(negedge clk) begin
    if (!reset) begin
      if (mem_req_v) begin
        req_log.push_back(mem_req);
      end
      if (io_resp_v) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("host response at %0t without a command before it", $time);
        end else begin
          check_resp("io_resp_o", io_resp, exp_q.pop_front());
        end
      end
    end
  end

  // ==============================
  // Stimulus helpers
  // ==============================
  task automatic host_access(input logic wr, input logic [CSR_ADDR_W-1:0] addr,
                             input word_t data, input word_t exp_data);
    io_resp_t exp;
    exp.wr   = wr;
    exp.addr = addr;
    exp.data = wr ? '0 : exp_data;
    @(negedge clk);
    io_cmd_v    = 1'b1;
    io_cmd.wr   = wr;
    io_cmd.addr = addr;
    io_cmd.data = data;
    exp_q.push_back(exp);
    @(negedge clk);
    io_cmd_v = 1'b0;
    // The response belongs to the cycle right after the command.
    if (io_resp_v !== 1'b1) begin
      errors++;
      $display("no host response one cycle after the command at %0t", $time);
      void'(exp_q.pop_back());
    end
  endtask

  task automatic drain_responses();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (u_vdp_top.done !== 1'b1 && cycles < DONE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= DONE_LIMIT) begin
      errors++;
      $display("engine gave no done pulse within %0d cycles", DONE_LIMIT);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    drain_responses();
    if (errors == err_start) begin
      $display("test %-14s ok", name);
    end else begin
      $display("test %-14s %0d mismatches", name, errors - err_start);
    end
  endtask

  task automatic run_job(input string name, input addr_t a_ptr, input addr_t b_ptr,
                         input addr_t res_ptr, input int len);
    int       err_start;
    int       n;
    word_t    exp_sum;
    mem_req_t req;
    err_start = errors;
    n         = (len > NUM_LANES) ? NUM_LANES : len;
    exp_sum   = dot_ref(va, vb, len);
    for (int i = 0; i < NUM_LANES; i++) begin
      u_mem.preload(a_ptr + addr_t'(i * ELEM_BYTES), va[i]);
      u_mem.preload(b_ptr + addr_t'(i * ELEM_BYTES), vb[i]);
    end
    req_log.delete();
    host_access(1'b1, CSR_A_PTR, word_t'(a_ptr), '0);
    host_access(1'b1, CSR_B_PTR, word_t'(b_ptr), '0);
    host_access(1'b1, CSR_RES_PTR, word_t'(res_ptr), '0);
    host_access(1'b1, CSR_LEN, word_t'(len), '0);
    host_access(1'b0, CSR_LEN, '0, word_t'(n));
    host_access(1'b1, CSR_START, 64'd1, '0);
    host_access(1'b0, CSR_STATUS, '0, 64'd0);  // Busy.
    wait_done();
    host_access(1'b0, CSR_STATUS, '0, 64'd1);
    host_access(1'b0, CSR_START, '0, 64'd0);
    if (req_log.size() != 2 * n + 1) begin
      errors++;
      $display("%s: expected %0d memory requests, saw %0d", name, 2 * n + 1, req_log.size());
    end else begin
      for (int i = 0; i < 2 * n; i++) begin
        req = req_log[i];
        if (req.wr) begin
          errors++;
          $display("%s: element request %0d went out as a store", name, i);
        end
        check_addr("mem_req_o.addr", req.addr, ((i < n) ? a_ptr : b_ptr) +
                   addr_t'((i % (n == 0 ? 1 : n)) * ELEM_BYTES));
      end
      req = req_log[2 * n];
      if (!req.wr) begin
        errors++;
        $display("%s: last request was not a store", name);
      end
      check_addr("mem_req_o.addr", req.addr, res_ptr);
      check_word("mem_req_o.data", req.data, exp_sum);
    end
    report_test(name, err_start);
  endtask

  task automatic fill_random();
    for (int i = 0; i < NUM_LANES; i++) begin
      va[i] = {$urandom, $urandom};
      vb[i] = {$urandom, $urandom};
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int err_start;
    addr_t base;
    errors   = 0;
    checks   = 0;
    clk      = 1'b0;
    reset    = 1'b1;
    io_cmd_v = 1'b0;
    io_cmd   = '0;
    void'($urandom(32'h4e1f_09ac));
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    err_start = errors;
    host_access(1'b0, CSR_STATUS, '0, 64'd1);
    host_access(1'b0, CSR_START, '0, 64'd0);
    report_test("reset_status", err_start);

    err_start = errors;
    host_access(1'b1, CSR_A_PTR, 64'hffff_0000_1234_5678, '0);
    host_access(1'b1, CSR_B_PTR, 64'h0000_0000_8000_0040, '0);
    host_access(1'b1, CSR_RES_PTR, 64'h0000_0000_0bad_f000, '0);
    host_access(1'b1, CSR_LEN, 64'd5, '0);
    host_access(1'b0, CSR_A_PTR, '0, 64'h1234_5678);
    host_access(1'b0, CSR_B_PTR, '0, 64'h8000_0040);
    host_access(1'b0, CSR_RES_PTR, '0, 64'h0bad_f000);
    host_access(1'b0, CSR_LEN, '0, 64'd5);
    host_access(1'b1, CSR_LEN, 64'd100, '0);
    host_access(1'b0, CSR_LEN, '0, 64'd8);  // Clamped.
    host_access(1'b0, 12'h180, '0, 64'd0);  // Unmapped offset.
    report_test("registers", err_start);

    for (int i = 0; i < NUM_LANES; i++) begin
      va[i] = word_t'(i + 1);
      vb[i] = 64'h100 + word_t'(i);
    end
    run_job("full_len", 32'h0000_1000, 32'h0000_2000, 32'h0000_3000, 8);
    fill_random();
    run_job("len_3", 32'h0000_4000, 32'h0000_4040, 32'h0000_4100, 3);
    run_job("len_0", 32'h0000_5000, 32'h0000_5040, 32'h0000_5100, 0);
    fill_random();
    run_job("len_12", 32'h0000_6000, 32'h0000_6040, 32'h0000_6100, 12);

    for (int k = 0; k < 20; k++) begin
      fill_random();
      base = 32'h0010_0000 + addr_t'($urandom_range(255)) * 32'h1000;
      run_job($sformatf("random_%0d", k), base, base + 32'h200, base + 32'h400,
              int'($urandom_range(12)));
    end

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog sized from the worst case of every job.
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t before the tests finished", $time);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/vdp_pkg.sv
logic/vdp_csr.sv
logic/vdp_fetch_ctrl.sv
logic/vdp_lane.sv
logic/vdp_adder_tree.sv
logic/vdp_top.sv
test/vdp_mem_model.sv
test/vdp_tb.sv

/* Bender.yml */
package:
  name: vdp

sources:
  - logic/vdp_pkg.sv
  - logic/vdp_csr.sv
  - logic/vdp_fetch_ctrl.sv
  - logic/vdp_lane.sv
  - logic/vdp_adder_tree.sv
  - logic/vdp_top.sv
  - target: test
    files:
      - test/vdp_mem_model.sv
      - test/vdp_tb.sv
